//--- logic/video_geom_pkg.sv
package video_geom_pkg;

   localparam int COLS_DEF = 16;  // Characters per text row
   localparam int ROWS_DEF = 4;   // Text rows per frame

   // The font address is {code, scan}, so the glyph height must stay a power of two
   localparam int GLYPH_H  = 8;
   localparam int SCAN_W   = 3;

   localparam int CODE_W   = 8;   // One character code per text memory byte
   localparam int PIX_W    = 8;   // One font byte covers the 8 pixels of a cell

endpackage

//--- logic/mem_map_pkg.sv
package mem_map_pkg;

   localparam int TEXT_AW = 12;

   // Font byte for a glyph line sits at {code, scan}
   localparam int FONT_AW = video_geom_pkg::CODE_W + video_geom_pkg::SCAN_W;

   localparam logic [TEXT_AW-1:0] TEXT_BASE_DEF = 12'h400;  // First character of the screen

endpackage

//--- logic/line_sequencer.sv
module line_sequencer #(
   parameter int ROWS = video_geom_pkg::ROWS_DEF
) (
   input  logic                              sys_clk,
   input  logic                              arst_n,
   input  logic                              scale,
   input  logic                              fetch_done,
   input  logic                              render_done,
   input  logic                              half_free,
   output logic                              fetch_start,
   output logic                              render_start,
   output logic                              render_half,
   output logic                              fill_done,
   output logic                              fill_half,
   output logic                              frame_scale,
   output logic [video_geom_pkg::SCAN_W-1:0] render_scan
);
   import video_geom_pkg::*;

   localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;

   typedef enum logic [1:0] {SQ_IDLE, SQ_FETCH, SQ_RENDER} sq_state_t;

   sq_state_t         state;
   logic [ROW_W-1:0]  row_q;
   logic [SCAN_W-1:0] scan_q;
   logic              next_half;  // Half that the next render fills
   logic              out_half;   // Oldest half still held by scanout
   logic [1:0]        scan_own;

   assign render_half = next_half;
   assign render_scan = scan_q;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state        <= SQ_IDLE;
         row_q        <= '0;
         scan_q       <= '0;
         next_half    <= 1'b0;
         out_half     <= 1'b0;
         scan_own     <= 2'b00;
         fetch_start  <= 1'b0;
         render_start <= 1'b0;
         fill_done    <= 1'b0;
         fill_half    <= 1'b0;
         frame_scale  <= 1'b0;
      end else begin
         fetch_start  <= 1'b0;
         render_start <= 1'b0;
         fill_done    <= 1'b0;

         // Halves leave scanout in the order they were filled
         if (half_free) begin
            scan_own[out_half] <= 1'b0;
            out_half           <= ~out_half;
         end

         case (state)
            SQ_IDLE: begin
               if (!scan_own[next_half]) begin
                  if (scan_q == '0) begin
                     fetch_start <= 1'b1;
                     state       <= SQ_FETCH;
                     if (row_q == '0) begin
                        frame_scale <= scale;  // Scale is fixed for the whole frame
                     end
                  end else begin
                     render_start <= 1'b1;
                     state        <= SQ_RENDER;
                  end
               end
            end
            SQ_FETCH: begin
               if (fetch_done) begin
                  render_start <= 1'b1;
                  state        <= SQ_RENDER;
               end
            end
            SQ_RENDER: begin
               if (render_done) begin
                  fill_done           <= 1'b1;
                  fill_half           <= next_half;
                  scan_own[next_half] <= 1'b1;
                  next_half           <= ~next_half;
                  state               <= SQ_IDLE;
                  if (scan_q == SCAN_W'(GLYPH_H - 1)) begin
                     scan_q <= '0;
                     row_q  <= (row_q == ROW_W'(ROWS - 1)) ? '0 : row_q + 1'b1;
                  end else begin
                     scan_q <= scan_q + 1'b1;
                  end
               end
            end
            default: state <= SQ_IDLE;
         endcase
      end
   end

   // The renderer must never overwrite a line that is still being scanned out
   a_render_half_free : assert property (@(posedge sys_clk) disable iff (!arst_n)
      render_start |-> !scan_own[render_half]);

endmodule

//--- logic/text_fetch.sv
module text_fetch #(
   parameter int                                COLS      = video_geom_pkg::COLS_DEF,
   parameter int                                ROWS      = video_geom_pkg::ROWS_DEF,
   parameter logic [mem_map_pkg::TEXT_AW-1:0]   TEXT_BASE = mem_map_pkg::TEXT_BASE_DEF,
   localparam int                               COL_W     = (COLS > 1) ? $clog2(COLS) : 1
) (
   input  logic                              sys_clk,
   input  logic                              arst_n,
   input  logic                              fetch_start,
   input  logic                              text_ack,
   input  logic [video_geom_pkg::CODE_W-1:0] text_data,
   input  logic [COL_W-1:0]                  code_idx,
   output logic                              fetch_done,
   output logic                              text_req,
   output logic [mem_map_pkg::TEXT_AW-1:0]   text_addr,
   output logic [video_geom_pkg::CODE_W-1:0] code
);
   import video_geom_pkg::*;
   import mem_map_pkg::*;

   // Last character of the screen, the address wraps back to the base after it
   localparam logic [TEXT_AW-1:0] TEXT_LAST = TEXT_AW'(TEXT_BASE + ROWS * COLS - 1);

   typedef enum logic [1:0] {TF_IDLE, TF_REQ, TF_GAP} tf_state_t;

   tf_state_t         state;
   logic [COL_W-1:0]  col_q;
   logic [CODE_W-1:0] row_codes [COLS];

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= TF_IDLE;
         col_q      <= '0;
         text_req   <= 1'b0;
         fetch_done <= 1'b0;
         text_addr  <= TEXT_BASE;
      end else begin
         fetch_done <= 1'b0;
         case (state)
            TF_IDLE: begin
               if (fetch_start) begin
                  col_q    <= '0;
                  text_req <= 1'b1;
                  state    <= TF_REQ;
               end
            end
            TF_REQ: begin
               if (text_ack) begin
                  text_req  <= 1'b0;  // One idle cycle between requests
                  text_addr <= (text_addr == TEXT_LAST) ? TEXT_BASE : text_addr + 1'b1;
                  if (col_q == COL_W'(COLS - 1)) begin
                     fetch_done <= 1'b1;
                     state      <= TF_IDLE;
                  end else begin
                     col_q <= col_q + 1'b1;
                     state <= TF_GAP;
                  end
               end
            end
            TF_GAP: begin
               text_req <= 1'b1;
               state    <= TF_REQ;
            end
            default: state <= TF_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (state == TF_REQ && text_ack) begin
         row_codes[col_q] <= text_data;
      end
   end

   assign code = row_codes[code_idx];  // Renderer reads the row without a wait state

   a_text_req_hold : assert property (@(posedge sys_clk) disable iff (!arst_n)
      text_req && !text_ack |=> text_req && $stable(text_addr));

endmodule

//--- logic/glyph_render.sv
module glyph_render #(
   parameter int  COLS  = video_geom_pkg::COLS_DEF,
   localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1
) (
   input  logic                              sys_clk,
   input  logic                              arst_n,
   input  logic                              render_start,
   input  logic                              render_half,
   input  logic                              font_ack,
   input  logic [video_geom_pkg::SCAN_W-1:0] render_scan,
   input  logic [video_geom_pkg::CODE_W-1:0] code,
   input  logic [video_geom_pkg::PIX_W-1:0]  font_data,
   output logic                              render_done,
   output logic                              font_req,
   output logic                              wr_en,
   output logic [COL_W-1:0]                  code_idx,
   output logic [mem_map_pkg::FONT_AW-1:0]   font_addr,
   output logic [COL_W:0]                    wr_addr,
   output logic [video_geom_pkg::PIX_W-1:0]  wr_bits
);
   import video_geom_pkg::*;

   typedef enum logic [1:0] {GR_IDLE, GR_ADDR, GR_WAIT} gr_state_t;

   gr_state_t         state;
   logic [COL_W-1:0]  col_q;
   logic              half_q;
   logic [SCAN_W-1:0] scan_q;

   assign code_idx = col_q;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= GR_IDLE;
         col_q       <= '0;
         font_req    <= 1'b0;
         wr_en       <= 1'b0;
         render_done <= 1'b0;
      end else begin
         wr_en       <= 1'b0;
         render_done <= 1'b0;
         case (state)
            GR_IDLE: begin
               if (render_start) begin
                  col_q <= '0;
                  state <= GR_ADDR;
               end
            end
            GR_ADDR: begin
               font_req <= 1'b1;  // Address is loaded in the same cycle
               state    <= GR_WAIT;
            end
            GR_WAIT: begin
               if (font_ack) begin
                  font_req <= 1'b0;
                  wr_en    <= 1'b1;
                  if (col_q == COL_W'(COLS - 1)) begin
                     render_done <= 1'b1;  // Lands with the last write
                     state       <= GR_IDLE;
                  end else begin
                     col_q <= col_q + 1'b1;
                     state <= GR_ADDR;
                  end
               end
            end
            default: state <= GR_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (state == GR_IDLE && render_start) begin
         half_q <= render_half;
         scan_q <= render_scan;
      end
      if (state == GR_ADDR) begin
         font_addr <= {code, scan_q};
      end
      if (state == GR_WAIT && font_ack) begin
         wr_addr <= {half_q, col_q};
         wr_bits <= font_data;
      end
   end

   a_font_req_hold : assert property (@(posedge sys_clk) disable iff (!arst_n)
      font_req && !font_ack |=> font_req && $stable(font_addr));

endmodule

//--- logic/line_buffer.sv
module line_buffer #(
   parameter int  COLS  = video_geom_pkg::COLS_DEF,
   parameter int  ROWS  = video_geom_pkg::ROWS_DEF,
   localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1
) (
   input  logic                             sys_clk,
   input  logic                             arst_n,
   input  logic                             wr_en,
   input  logic [COL_W:0]                   wr_addr,
   input  logic [video_geom_pkg::PIX_W-1:0] wr_bits,
   input  logic                             fill_done,
   input  logic                             fill_half,
   input  logic                             frame_scale,
   input  logic                             pix_ready,
   output logic                             half_free,
   output logic                             pix_valid,
   output logic                             pix_sol,
   output logic                             pix_sof,
   output logic [video_geom_pkg::PIX_W-1:0] pix_bits
);
   import video_geom_pkg::*;

   localparam int LINES  = ROWS * GLYPH_H;
   localparam int LINE_W = $clog2(LINES);

   logic [PIX_W-1:0]  line_mem [2][COLS];
   logic [1:0]        filled;
   logic [1:0]        half_scale;  // Scale mode of the frame each half belongs to
   logic              rd_half;
   logic              rep_q;       // Second play of a doubled line
   logic [COL_W-1:0]  rd_col;
   logic [LINE_W-1:0] line_q;
   logic              xfer;

   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         line_mem[wr_addr[COL_W]][wr_addr[COL_W-1:0]] <= wr_bits;
      end
   end

   assign pix_valid = filled[rd_half];
   assign pix_bits  = line_mem[rd_half][rd_col];
   assign pix_sol   = (rd_col == '0);
   assign pix_sof   = pix_sol && !rep_q && (line_q == '0);
   assign xfer      = pix_valid && pix_ready;

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         filled     <= 2'b00;
         half_scale <= 2'b00;
         rd_half    <= 1'b0;
         rep_q      <= 1'b0;
         rd_col     <= '0;
         line_q     <= '0;
         half_free  <= 1'b0;
      end else begin
         half_free <= 1'b0;
         if (fill_done) begin
            filled[fill_half]     <= 1'b1;
            half_scale[fill_half] <= frame_scale;
         end
         if (xfer) begin
            if (rd_col == COL_W'(COLS - 1)) begin
               rd_col <= '0;
               if (half_scale[rd_half] && !rep_q) begin
                  rep_q <= 1'b1;  // Play the same half once more
               end else begin
                  rep_q           <= 1'b0;
                  filled[rd_half] <= 1'b0;
                  half_free       <= 1'b1;
                  rd_half         <= ~rd_half;
                  line_q          <= (line_q == LINE_W'(LINES - 1)) ? '0 : line_q + 1'b1;
               end
            end else begin
               rd_col <= rd_col + 1'b1;
            end
         end
      end
   end

   a_pix_hold : assert property (@(posedge sys_clk) disable iff (!arst_n)
      pix_valid && !pix_ready |=> pix_valid && $stable(pix_bits) && $stable(pix_sof));

endmodule

//--- logic/text_display.sv
module text_display #(
   parameter int                              COLS      = video_geom_pkg::COLS_DEF,
   parameter int                              ROWS      = video_geom_pkg::ROWS_DEF,
   parameter logic [mem_map_pkg::TEXT_AW-1:0] TEXT_BASE = mem_map_pkg::TEXT_BASE_DEF
) (
   input  logic                              sys_clk,
   input  logic                              arst_n,
   input  logic                              scale,
   output logic [mem_map_pkg::TEXT_AW-1:0]   text_addr,
   output logic                              text_req,
   input  logic [video_geom_pkg::CODE_W-1:0] text_data,
   input  logic                              text_ack,
   output logic [mem_map_pkg::FONT_AW-1:0]   font_addr,
   output logic                              font_req,
   input  logic [video_geom_pkg::PIX_W-1:0]  font_data,
   input  logic                              font_ack,
   output logic                              pix_valid,
   output logic [video_geom_pkg::PIX_W-1:0]  pix_bits,
   output logic                              pix_sol,
   output logic                              pix_sof,
   input  logic                              pix_ready
);
   import video_geom_pkg::*;

   localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1;

   logic              fetch_start;
   logic              fetch_done;
   logic              render_start;
   logic              render_done;
   logic              render_half;
   logic [SCAN_W-1:0] render_scan;
   logic              fill_done;
   logic              fill_half;
   logic              frame_scale;
   logic              half_free;
   logic [COL_W-1:0]  code_idx;
   logic [CODE_W-1:0] code;
   logic              wr_en;
   logic [COL_W:0]    wr_addr;   // {half, column}
   logic [PIX_W-1:0]  wr_bits;

   line_sequencer #(
      .ROWS (ROWS)
   ) u_line_sequencer (
      .sys_clk      (sys_clk),
      .arst_n       (arst_n),
      .scale        (scale),
      .fetch_done   (fetch_done),
      .render_done  (render_done),
      .half_free    (half_free),
      .fetch_start  (fetch_start),
      .render_start (render_start),
      .render_half  (render_half),
      .fill_done    (fill_done),
      .fill_half    (fill_half),
      .frame_scale  (frame_scale),
      .render_scan  (render_scan)
   );

   text_fetch #(
      .COLS      (COLS),
      .ROWS      (ROWS),
      .TEXT_BASE (TEXT_BASE)
   ) u_text_fetch (
      .sys_clk     (sys_clk),
      .arst_n      (arst_n),
      .fetch_start (fetch_start),
      .text_ack    (text_ack),
      .text_data   (text_data),
      .code_idx    (code_idx),
      .fetch_done  (fetch_done),
      .text_req    (text_req),
      .text_addr   (text_addr),
      .code        (code)
   );

   glyph_render #(
      .COLS (COLS)
   ) u_glyph_render (
      .sys_clk      (sys_clk),
      .arst_n       (arst_n),
      .render_start (render_start),
      .render_half  (render_half),
      .font_ack     (font_ack),
      .render_scan  (render_scan),
      .code         (code),
      .font_data    (font_data),
      .render_done  (render_done),
      .font_req     (font_req),
      .wr_en        (wr_en),
      .code_idx     (code_idx),
      .font_addr    (font_addr),
      .wr_addr      (wr_addr),
      .wr_bits      (wr_bits)
   );

   line_buffer #(
      .COLS (COLS),
      .ROWS (ROWS)
   ) u_line_buffer (
      .sys_clk     (sys_clk),
      .arst_n      (arst_n),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_bits     (wr_bits),
      .fill_done   (fill_done),
      .fill_half   (fill_half),
      .frame_scale (frame_scale),
      .pix_ready   (pix_ready),
      .half_free   (half_free),
      .pix_valid   (pix_valid),
      .pix_sol     (pix_sol),
      .pix_sof     (pix_sof),
      .pix_bits    (pix_bits)
   );

endmodule

//--- verification/display_checker.sv
module display_checker #(
   parameter int                              COLS      = video_geom_pkg::COLS_DEF,
   parameter int                              ROWS      = video_geom_pkg::ROWS_DEF,
   parameter logic [mem_map_pkg::TEXT_AW-1:0] TEXT_BASE = mem_map_pkg::TEXT_BASE_DEF
) (
   input  logic                              sys_clk,
   input  logic                              arst_n,
   input  logic                              scale,
   input  logic                              text_req,
   input  logic                              text_ack,
   input  logic [mem_map_pkg::TEXT_AW-1:0]   text_addr,
   input  logic                              font_req,
   input  logic                              font_ack,
   input  logic [mem_map_pkg::FONT_AW-1:0]   font_addr,
   input  logic                              pix_valid,
   input  logic                              pix_ready,
   input  logic [video_geom_pkg::PIX_W-1:0]  pix_bits,
   input  logic                              pix_sol,
   input  logic                              pix_sof,
   output int                                err_count,
   output int                                xfers,
   output int                                frames,
   output int                                text_reads,
   output int                                frame_lines,
   output logic [1:0]                        first_flags
);
   timeunit 1ns;
   timeprecision 1ps;
   import video_geom_pkg::*;
   import mem_map_pkg::*;

   localparam int LINES  = ROWS * GLYPH_H;
   localparam int SCREEN = ROWS * COLS;

   int                 line_m;      // Scanout position in the frame model
   int                 col_m;
   int                 lines_seen;
   int                 rl;          // Render position, one font read per column
   int                 rc;
   logic               rep_m;
   logic               scale_m;
   logic               exp_sol;
   logic               exp_sof;
   logic [PIX_W-1:0]   exp_bits;
   logic [TEXT_AW-1:0] next_taddr;
   logic               prev_treq;
   logic               prev_tack;
   logic               prev_freq;
   logic               prev_fack;
   logic [TEXT_AW-1:0] prev_taddr;
   logic [FONT_AW-1:0] prev_faddr;

   // Every frame shows the same screen because the text address wraps per frame
   function automatic logic [CODE_W-1:0] code_at(input int line, input int col);
      logic [TEXT_AW-1:0] addr;
      addr = TEXT_BASE + TEXT_AW'((line / GLYPH_H) * COLS + col);
      return tb_text_display.text_mem[addr];
   endfunction

   function automatic logic [FONT_AW-1:0] glyph_addr(input int line, input int col);
      return {code_at(line, col), SCAN_W'(line % GLYPH_H)};
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("ERROR %s: %s expected %0h actual %0h", tb_text_display.test_name, what, exp, act);
      err_count++;
   endtask

   task automatic report_failure(input string what);
      $display("Failure in %s: %s", tb_text_display.test_name, what);
      err_count++;
   endtask

   always @(posedge sys_clk) begin
      if (!arst_n) begin
         line_m      = 0;
         col_m       = 0;
         lines_seen  = 0;
         rl          = 0;
         rc          = 0;
         rep_m       = 1'b0;
         scale_m     = 1'b0;
         next_taddr  = TEXT_BASE;
         prev_treq   = 1'b0;
         prev_tack   = 1'b0;
         prev_freq   = 1'b0;
         prev_fack   = 1'b0;
         first_flags = 2'b00;
      end else begin
         if (prev_tack && text_req) begin
            report_failure("text_req was still high in the cycle after text_ack");
         end
         if (prev_treq && !prev_tack && (!text_req || text_addr !== prev_taddr)) begin
            report_failure("text_req fell or text_addr moved before text_ack");
         end
         if (prev_fack && font_req) begin
            report_failure("font_req was still high in the cycle after font_ack");
         end
         if (prev_freq && !prev_fack && (!font_req || font_addr !== prev_faddr)) begin
            report_failure("font_req fell or font_addr moved before font_ack");
         end
         if (text_req && text_ack) begin
            if (text_addr !== next_taddr) begin
               report_mismatch("text address", 32'(next_taddr), 32'(text_addr));
            end
            next_taddr = (next_taddr == TEXT_AW'(TEXT_BASE + SCREEN - 1)) ?
                         TEXT_BASE : next_taddr + TEXT_AW'(1);
            text_reads++;
         end
         if (font_req && font_ack) begin
            if (font_addr !== glyph_addr(rl, rc)) begin
               report_mismatch($sformatf("font address line %0d col %0d", rl, rc),
                               32'(glyph_addr(rl, rc)), 32'(font_addr));
            end
            rc++;
            if (rc == COLS) begin
               rc = 0;
               rl = (rl + 1) % LINES;
            end
         end
         if (pix_valid && pix_ready) begin
            if (col_m == 0 && !rep_m && line_m == 0) begin
               scale_m = scale;  // Scale only changes right after a frame's first byte
            end
            if (xfers == 0) begin
               first_flags = {pix_sof, pix_sol};
            end
            exp_sol  = (col_m == 0);
            exp_sof  = exp_sol && !rep_m && (line_m == 0);
            exp_bits = tb_text_display.font_mem[glyph_addr(line_m, col_m)];
            if (pix_bits !== exp_bits) begin
               report_mismatch($sformatf("pixel byte line %0d col %0d", line_m, col_m),
                               32'(exp_bits), 32'(pix_bits));
            end
            if (pix_sol !== exp_sol || pix_sof !== exp_sof) begin
               report_mismatch($sformatf("sof and sol at line %0d col %0d", line_m, col_m),
                               32'({exp_sof, exp_sol}), 32'({pix_sof, pix_sol}));
            end
            if (pix_sof) begin
               frames++;
               frame_lines = lines_seen;
               lines_seen  = 0;
            end
            if (pix_sol) begin
               lines_seen++;
            end
            xfers++;
            col_m++;
            if (col_m == COLS) begin
               col_m = 0;
               if (scale_m && !rep_m) begin
                  rep_m = 1'b1;
               end else begin
                  rep_m  = 1'b0;
                  line_m = (line_m + 1) % LINES;
               end
            end
         end
         prev_treq  = text_req;
         prev_tack  = text_ack;
         prev_taddr = text_addr;
         prev_freq  = font_req;
         prev_fack  = font_ack;
         prev_faddr = font_addr;
      end
   end

endmodule

//--- verification/tb_text_display.sv
module tb_text_display;
   timeunit 1ns;
   timeprecision 1ps;
   import video_geom_pkg::*;
   import mem_map_pkg::*;

   localparam int                 COLS        = COLS_DEF;
   localparam int                 ROWS        = ROWS_DEF;
   localparam logic [TEXT_AW-1:0] TEXT_BASE   = TEXT_BASE_DEF;
   localparam int                 FRAME_LIMIT = 20000;  // Generous even when scaled and stalled
   localparam int                 BY_XFERS    = 0;
   localparam int                 BY_FRAMES   = 1;
   localparam int                 BY_READS    = 2;
   localparam int                 BY_SCALE    = 3;

   logic               sys_clk = 1'b0;
   logic               arst_n;
   logic               scale = 1'b0;
   logic               text_ack = 1'b0;
   logic [CODE_W-1:0]  text_data = '0;
   logic               font_ack = 1'b0;
   logic [PIX_W-1:0]   font_data = '0;
   logic               pix_ready = 1'b1;
   logic               text_req;
   logic               font_req;
   logic [TEXT_AW-1:0] text_addr;
   logic [FONT_AW-1:0] font_addr;
   logic               pix_valid;
   logic               pix_sol;
   logic               pix_sof;
   logic [PIX_W-1:0]   pix_bits;

   logic [CODE_W-1:0]  text_mem [2**TEXT_AW];
   logic [PIX_W-1:0]   font_mem [2**FONT_AW];
   logic [31:0]        lfsr = 32'h3a29_cc4a;
   logic [1:0]         text_wait = '0;
   logic [1:0]         font_wait = '0;
   logic               ready_random = 1'b0;
   logic               scale_next = 1'b0;
   logic               sof_xfer_q = 1'b0;
   logic               timed_out = 1'b0;
   string              test_name = "reset_state";
   int                 tests_run = 0;
   int                 tests_failed = 0;
   int                 tb_errs = 0;
   int                 err_base = 0;
   int                 err_count;
   int                 xfers;
   int                 frames;
   int                 text_reads;
   int                 frame_lines;
   logic [1:0]         first_flags;

   always #5 sys_clk = ~sys_clk;

   text_display #(.COLS(COLS), .ROWS(ROWS), .TEXT_BASE(TEXT_BASE)) u_dut (
      .sys_clk(sys_clk), .arst_n(arst_n), .scale(scale),
      .text_addr(text_addr), .text_req(text_req), .text_data(text_data), .text_ack(text_ack),
      .font_addr(font_addr), .font_req(font_req), .font_data(font_data), .font_ack(font_ack),
      .pix_valid(pix_valid), .pix_bits(pix_bits), .pix_sol(pix_sol), .pix_sof(pix_sof),
      .pix_ready(pix_ready)
   );

   display_checker #(.COLS(COLS), .ROWS(ROWS), .TEXT_BASE(TEXT_BASE)) u_checker (
      .sys_clk(sys_clk), .arst_n(arst_n), .scale(scale),
      .text_req(text_req), .text_ack(text_ack), .text_addr(text_addr),
      .font_req(font_req), .font_ack(font_ack), .font_addr(font_addr),
      .pix_valid(pix_valid), .pix_ready(pix_ready), .pix_bits(pix_bits),
      .pix_sol(pix_sol), .pix_sof(pix_sof), .err_count(err_count), .xfers(xfers),
      .frames(frames), .text_reads(text_reads), .frame_lines(frame_lines),
      .first_flags(first_flags)
   );

   // Galois LFSR stepped once for every bit handed out
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits = {bits[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
      end
      return bits;
   endfunction

   // Memory models answer one request at a time after 0 to 3 idle cycles
   always @(negedge sys_clk) begin
      if (text_ack) begin
         text_ack <= 1'b0;
      end else if (text_req) begin
         if (text_wait == '0) begin
            text_ack  <= 1'b1;
            text_data <= text_mem[text_addr];
            text_wait <= 2'(take_bits(2));
         end else begin
            text_wait <= text_wait - 2'd1;
         end
      end
      if (font_ack) begin
         font_ack <= 1'b0;
      end else if (font_req) begin
         if (font_wait == '0) begin
            font_ack  <= 1'b1;
            font_data <= font_mem[font_addr];
            font_wait <= 2'(take_bits(2));
         end else begin
            font_wait <= font_wait - 2'd1;
         end
      end
      pix_ready <= ready_random ? (take_bits(2) != 0) : 1'b1;
      if (sof_xfer_q) begin
         scale <= scale_next;  // Changes land just after a frame's first byte
      end
   end

   always @(posedge sys_clk) begin
      sof_xfer_q <= pix_valid && pix_ready && pix_sof;
   end

   function automatic int progress(input int kind);
      case (kind)
         BY_XFERS:  return xfers;
         BY_FRAMES: return frames;
         BY_READS:  return text_reads;
         default:   return int'(scale);
      endcase
   endfunction

   task automatic wait_progress(input int kind, input int target, input int limit);
      int cycles;
      cycles = 0;
      while (progress(kind) != target && cycles < limit) begin
         @(negedge sys_clk);
         cycles++;
      end
      if (progress(kind) != target) begin
         $display("Timeout in %s: count did not reach %0d within %0d cycles",
                  test_name, target, limit);
         timed_out = 1'b1;
      end
   endtask

   task automatic expect_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      if (act !== exp) begin
         $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
         tb_errs++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_base  = err_count + tb_errs;
   endtask

   task automatic end_test();
      int errs;
      errs = err_count + tb_errs - err_base;
      tests_run++;
      if (errs == 0 && !timed_out) begin
         $display("%s: ok", test_name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", test_name, errs);
      end
   endtask

   initial begin
      arst_n = 1'b0;
      for (int i = 0; i < 2**TEXT_AW; i++) begin
         text_mem[TEXT_AW'(i)] = CODE_W'(take_bits(CODE_W));
      end
      for (int i = 0; i < 2**FONT_AW; i++) begin
         font_mem[FONT_AW'(i)] = PIX_W'(take_bits(PIX_W));
      end
      start_test("reset_state");
      repeat (16) @(negedge sys_clk);
      expect_value("pix_valid in reset", 32'd0, 32'(pix_valid));
      expect_value("text_req in reset", 32'd0, 32'(text_req));
      expect_value("font_req in reset", 32'd0, 32'(font_req));
      arst_n = 1'b1;
      @(negedge sys_clk);
      expect_value("pix_valid after reset", 32'd0, 32'(pix_valid));
      expect_value("text_req after reset", 32'd0, 32'(text_req));
      expect_value("font_req after reset", 32'd0, 32'(font_req));
      wait_progress(BY_XFERS, 1, FRAME_LIMIT);
      expect_value("first byte sof and sol", 32'd3, 32'(first_flags));
      end_test();
      if (!timed_out) begin
         start_test("pixel_content");
         wait_progress(BY_FRAMES, frames + 3, 3 * FRAME_LIMIT);
         end_test();
      end
      if (!timed_out) begin
         start_test("back_pressure");
         @(posedge sys_clk);
         ready_random = 1'b1;
         wait_progress(BY_FRAMES, frames + 2, 2 * FRAME_LIMIT);
         end_test();
      end
      if (!timed_out) begin
         start_test("memory_handshake");
         wait_progress(BY_READS, text_reads + 2 * ROWS * COLS, 3 * FRAME_LIMIT);
         end_test();
      end
      if (!timed_out) begin
         start_test("scale_mode");
         @(posedge sys_clk);
         scale_next = 1'b1;
         wait_progress(BY_SCALE, 1, 2 * FRAME_LIMIT);
         wait_progress(BY_FRAMES, frames + 2, 4 * FRAME_LIMIT);
         expect_value("lines in a scaled frame", 32'(2 * ROWS * GLYPH_H), 32'(frame_lines));
         @(posedge sys_clk);
         scale_next = 1'b0;
         wait_progress(BY_SCALE, 0, 4 * FRAME_LIMIT);
         wait_progress(BY_FRAMES, frames + 2, 4 * FRAME_LIMIT);
         expect_value("lines in a plain frame", 32'(ROWS * GLYPH_H), 32'(frame_lines));
         end_test();
      end
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
               err_count + tb_errs);
      if (tests_failed == 0 && err_count + tb_errs == 0 && !timed_out) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- text_display.f
logic/video_geom_pkg.sv
logic/mem_map_pkg.sv
logic/line_sequencer.sv
logic/text_fetch.sv
logic/glyph_render.sv
logic/line_buffer.sv
logic/text_display.sv
verification/display_checker.sv
verification/tb_text_display.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f text_display.f --top-module tb_text_display -o tb_text_display

out=$(./obj_dir/tb_text_display)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1
